// File: commit_mask.sv
`timescale 1ns/1ps
`default_nettype none

module commit_mask (
    input  wire                      single_step,
    input  wire rob_pkg::window_t    window,
    output rob_pkg::commit_flags_t   flags
);

    import rob_pkg::*;

    logic [commit_w-1:0] ready_vec;
    logic [commit_w-1:0] is_branch;
    logic [commit_w-1:0] is_store;
    logic [commit_w-1:0] is_csr_wr;
    logic [commit_w-1:0] is_excp;
    logic [commit_w-1:0] is_ertn;
    logic [commit_w-1:0] is_idle;

    logic [commit_w-1:0] prefix_mask;
    logic [commit_w-1:0] store_mask;
    logic [commit_w-1:0] csr_mask;
    logic [commit_w-1:0] branch_mask;
    logic [commit_w-1:0] excp_mask;
    logic [commit_w-1:0] ertn_mask;
    logic [commit_w-1:0] idle_mask;
    logic [commit_w-1:0] step_mask;
    logic [commit_w-1:0] final_mask;
    logic                find_excp;

    // ------------------------------
    // truncation helpers
    // ------------------------------

    // greedy up to just before the second hit
    function automatic logic [commit_w-1:0] keep_one(input logic [commit_w-1:0] hit);
        logic [commit_w-1:0] keep;
        int unsigned         seen;

        seen = 0;
        for (int i = 0; i < commit_w; i++) begin
            seen    = seen + 32'(hit[i]);
            keep[i] = (seen <= 1);
        end
        return keep;
    endfunction

    // first hit closes the group
    function automatic logic [commit_w-1:0] last_hit(input logic [commit_w-1:0] hit);
        logic [commit_w-1:0] keep;
        logic                seen;

        seen = 1'b0;
        for (int i = 0; i < commit_w; i++) begin
            keep[i] = ~seen;
            seen    = seen | hit[i];
        end
        return keep;
    endfunction

    // hit only at slot 0 and alone, otherwise stop before it
    function automatic logic [commit_w-1:0] solo_hit(input logic [commit_w-1:0] hit);
        logic [commit_w-1:0] keep;
        logic                seen;

        seen = 1'b0;
        for (int i = 0; i < commit_w; i++) begin
            seen    = seen | hit[i];
            keep[i] = (i == 0) ? 1'b1 : ~seen;
        end
        return keep;
    endfunction

    // ------------------------------
    // slot decode
    // ------------------------------
    for (genvar i = 0; i < commit_w; i++) begin : g_dec
        assign ready_vec[i] = window[i].occupied & window[i].done;
        assign is_branch[i] = (window[i].op_class == branch);
        assign is_store[i]  = (window[i].op_class == store);
        assign is_csr_wr[i] = (window[i].op_class == csr_wr);
        assign is_excp[i]   = (window[i].op_class == excp);
        assign is_ertn[i]   = (window[i].op_class == ertn);
        assign is_idle[i]   = (window[i].op_class == idle);
    end

    // ready prefix from the head
    always_comb begin
        prefix_mask[0] = ready_vec[0];
        for (int i = 1; i < commit_w; i++) begin
            prefix_mask[i] = prefix_mask[i-1] & ready_vec[i];
        end
    end

    assign store_mask  = keep_one(is_store);
    assign csr_mask    = keep_one(is_csr_wr);
    assign branch_mask = last_hit(is_branch);
    assign excp_mask   = solo_hit(is_excp);
    assign ertn_mask   = solo_hit(is_ertn);
    assign idle_mask   = solo_hit(is_idle);
    assign step_mask   = single_step ? commit_w'(1) : '1;

    assign final_mask = prefix_mask & store_mask & csr_mask & branch_mask
                      & excp_mask & ertn_mask & idle_mask & step_mask;

    assign find_excp = final_mask[0] & is_excp[0];

    // ------------------------------
    // event flags
    // ------------------------------
    always_comb begin
        flags.mask        = final_mask;
        flags.find_excp   = find_excp;
        flags.find_ertn   = ~find_excp & final_mask[0] & is_ertn[0];
        flags.find_idle   = ~find_excp & final_mask[0] & is_idle[0];
        flags.find_store  = ~find_excp & (|(final_mask & is_store));
        flags.find_csr_wr = ~find_excp & (|(final_mask & is_csr_wr));
        flags.find_branch = ~find_excp & (|(final_mask & is_branch));

        // at most one branch can sit inside the mask
        flags.branch_slot = no_branch;
        for (int i = 0; i < commit_w; i++) begin
            if (final_mask[i] && is_branch[i] && !find_excp) begin
                flags.branch_slot = slot_w'(i);
            end
        end
    end

endmodule

`default_nettype wire

// File: retire_unit.sv
`timescale 1ns/1ps
`default_nettype none

module retire_unit (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire rob_pkg::commit_flags_t  flags,
    input  wire rob_pkg::window_t        window,
    input  wire                          wake,

    output logic                         retire_valid,
    output rob_pkg::retire_t             retire_data,
    input  wire                          retire_ready,

    output logic [rob_pkg::slot_w-1:0]   pop_count,
    output logic                         flush
);

    import rob_pkg::*;

    logic                halt_q;
    logic [commit_w-1:0] live_mask;
    logic [slot_w-1:0]   group_size;
    logic                fire;

    // ------------------------------
    // handshake
    // ------------------------------
    assign live_mask    = halt_q ? '0 : flags.mask;
    assign retire_valid = |live_mask;
    assign fire         = retire_valid & retire_ready;

    always_comb begin
        group_size = '0;
        for (int i = 0; i < commit_w; i++) begin
            group_size = group_size + slot_w'(live_mask[i]);
        end
    end

    assign pop_count = fire ? group_size : '0;

    // excp and ertn empty the buffer on the retiring edge
    assign flush = fire & (flags.find_excp | flags.find_ertn);

    // ------------------------------
    // retire group
    // ------------------------------
    always_comb begin
        retire_data            = '0;
        retire_data.mask       = live_mask;
        retire_data.flags      = flags;
        retire_data.flags.mask = live_mask;
        for (int i = 0; i < commit_w; i++) begin
            if (live_mask[i]) begin
                retire_data.tag[i] = window[i].tag;
                retire_data.pc[i]  = window[i].pc;
            end
        end
    end

    // idle halt, held until a wake pulse
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            halt_q <= 1'b0;
        end else if (fire && flags.find_idle) begin
            halt_q <= 1'b1;
        end else if (wake) begin
            halt_q <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: rob_commit_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit_chk (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          dispatch_valid,
    input  wire                          dispatch_ready,
    input  wire                          retire_valid,
    input  wire                          retire_ready,
    input  wire rob_pkg::commit_flags_t  flags,
    input  wire [rob_pkg::slot_w-1:0]    pop_count,
    input  wire                          flush
);

    import rob_pkg::*;

    logic [cnt_w-1:0] occ_q;

    // occupancy rebuilt from the handshakes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            occ_q <= '0;
        end else if (flush) begin
            occ_q <= '0;
        end else begin
            occ_q <= occ_q + cnt_w'(dispatch_valid & dispatch_ready) - cnt_w'(pop_count);
        end
    end

    flush_alone: assert property (@(posedge clk) disable iff (!rst_n)
        flush |-> (flags.mask == commit_w'(1)))
        else $error("flush group holds more than slot 0");

    flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !retire_valid)
        else $error("retire after flush");

    held_valid: assert property (@(posedge clk) disable iff (!rst_n)
        (retire_valid && !retire_ready) |=> retire_valid)
        else $error("retire_valid dropped while held");

    full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (occ_q == cnt_w'(rob_depth)) |-> !dispatch_ready)
        else $error("dispatch accepted into a full buffer");

endmodule

bind rob_commit_top rob_commit_chk u_chk (
    .clk            (clk),
    .rst_n          (rst_n),
    .dispatch_valid (dispatch_valid),
    .dispatch_ready (dispatch_ready),
    .retire_valid   (retire_valid),
    .retire_ready   (retire_ready),
    .flags          (flags),
    .pop_count      (pop_count),
    .flush          (flush)
);

`default_nettype wire

// File: rob_commit_top.sv
`timescale 1ns/1ps
`default_nettype none

module rob_commit_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          single_step,

    // dispatch
    input  wire                          dispatch_valid,
    input  wire rob_pkg::dispatch_t      dispatch_data,
    output logic                         dispatch_ready,
    output logic [rob_pkg::tag_w-1:0]    dispatch_tag,

    // completion
    input  wire                          complete_valid,
    input  wire [rob_pkg::tag_w-1:0]     complete_tag,

    input  wire                          wake,

    // retire
    output logic                         retire_valid,
    output rob_pkg::retire_t             retire_data,
    input  wire                          retire_ready
);

    import rob_pkg::*;

    window_t           window;
    commit_flags_t     flags;
    logic [slot_w-1:0] pop_count;
    logic              flush;

    rob_queue u_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .dispatch_valid (dispatch_valid),
        .dispatch_data  (dispatch_data),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .window         (window),
        .pop_count      (pop_count),
        .flush          (flush)
    );

    commit_mask u_mask (
        .single_step (single_step),
        .window      (window),
        .flags       (flags)
    );

    retire_unit u_retire (
        .clk          (clk),
        .rst_n        (rst_n),
        .flags        (flags),
        .window       (window),
        .wake         (wake),
        .retire_valid (retire_valid),
        .retire_data  (retire_data),
        .retire_ready (retire_ready),
        .pop_count    (pop_count),
        .flush        (flush)
    );

endmodule

`default_nettype wire

// File: rob_pkg.sv
`default_nettype none

package rob_pkg;

    // ------------------------------
    // sizes
    // ------------------------------
    localparam int rob_depth = 16;
    localparam int tag_w     = 4;
    localparam int commit_w  = 5;
    localparam int pc_w      = 32;

    // occupancy counter has to hold rob_depth itself
    localparam int cnt_w = tag_w + 1;

    // slot index and pop count width
    localparam int slot_w = 3;

    // branch_slot value when the group has no branch
    localparam logic [slot_w-1:0] no_branch = 3'd7;

    // ------------------------------
    // op classes
    // ------------------------------
    typedef enum logic [2:0] {
        plain  = 3'd0,
        branch = 3'd1,
        store  = 3'd2,
        csr_wr = 3'd3,
        excp   = 3'd4,
        ertn   = 3'd5,
        idle   = 3'd6
    } op_class_e;

    // dispatch payload, tag comes back from the buffer
    typedef struct packed {
        logic [pc_w-1:0] pc;
        op_class_e       op_class;
    } dispatch_t;

    // one head window slot, 41 bits
    typedef struct packed {
        logic             done;
        logic             occupied;
        op_class_e        op_class;
        logic [tag_w-1:0] tag;
        logic [pc_w-1:0]  pc;
    } slot_t;

    // slot 0 is the oldest entry
    typedef slot_t [commit_w-1:0] window_t;

    typedef struct packed {
        logic [commit_w-1:0] mask;
        logic [slot_w-1:0]   branch_slot;
        logic                find_branch;
        logic                find_store;
        logic                find_csr_wr;
        logic                find_excp;
        logic                find_ertn;
        logic                find_idle;
    } commit_flags_t;

    typedef struct packed {
        logic [commit_w-1:0]            mask;
        logic [commit_w-1:0][tag_w-1:0] tag;
        logic [commit_w-1:0][pc_w-1:0]  pc;
        commit_flags_t                  flags;
    } retire_t;

endpackage

`default_nettype wire

// File: rob_queue.sv
`timescale 1ns/1ps
`default_nettype none

module rob_queue (
    input  wire                          clk,
    input  wire                          rst_n,

    input  wire                          dispatch_valid,
    input  wire rob_pkg::dispatch_t      dispatch_data,
    output logic                         dispatch_ready,
    output logic [rob_pkg::tag_w-1:0]    dispatch_tag,

    input  wire                          complete_valid,
    input  wire [rob_pkg::tag_w-1:0]     complete_tag,

    output rob_pkg::window_t             window,
    input  wire [rob_pkg::slot_w-1:0]    pop_count,
    input  wire                          flush
);

    import rob_pkg::*;

    // payload storage
    dispatch_t            entry_q [rob_depth];

    // control state
    logic [rob_depth-1:0] done_q;
    logic [tag_w-1:0]     head_q;
    logic [tag_w-1:0]     tail_q;
    logic [cnt_w-1:0]     count_q;

    logic                 full;
    logic                 push;

    // ------------------------------
    // dispatch side
    // ------------------------------
    assign full           = (count_q == cnt_w'(rob_depth));
    assign dispatch_ready = ~full & ~flush;
    assign dispatch_tag   = tail_q;
    assign push           = dispatch_valid & dispatch_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            entry_q[tail_q] <= dispatch_data;
        end
    end

    // completion marks the entry and a new dispatch clears it again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_q <= '0;
        end else begin
            if (complete_valid) begin
                done_q[complete_tag] <= 1'b1;
            end
            if (push) begin
                done_q[tail_q] <= 1'b0;
            end
        end
    end

    // ------------------------------
    // pointers and occupancy
    // ------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            // dispatch is blocked here so tail is stable
            head_q  <= tail_q;
            count_q <= '0;
        end else begin
            head_q <= head_q + tag_w'(pop_count);
            if (push) begin
                tail_q <= tail_q + tag_w'(1);
            end
            count_q <= count_q + cnt_w'(push) - cnt_w'(pop_count);
        end
    end

    // ------------------------------
    // head window
    // ------------------------------
    always_comb begin
        logic [tag_w-1:0] idx;

        window = '0;
        for (int i = 0; i < commit_w; i++) begin
            // wraps on its own since depth is a power of two
            idx = head_q + tag_w'(i);
            if (cnt_w'(i) < count_q) begin
                window[i].done     = done_q[idx];
                window[i].occupied = 1'b1;
                window[i].op_class = entry_q[idx].op_class;
                window[i].tag      = idx;
                window[i].pc       = entry_q[idx].pc;
            end
        end
    end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_rob_commit \
    -f vlog.f \
    -o sim_rob_commit

./obj_dir/sim_rob_commit

// File: tb_rob_commit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_rob_commit;

    import rob_pkg::*;

    localparam int          n_ops      = 160;
    localparam int          clk_period = 100;
    localparam logic [31:0] seed       = 32'h68f0_42ea;

    logic                clk;
    logic                rst_n;
    logic                single_step;
    logic                dispatch_valid;
    dispatch_t           dispatch_data;
    logic                dispatch_ready;
    logic [tag_w-1:0]    dispatch_tag;
    logic                complete_valid;
    logic [tag_w-1:0]    complete_tag;
    logic                wake;
    logic                retire_valid;
    retire_t             retire_data;
    logic                retire_ready;

    // model of the buffer with index 0 at the head
    slot_t               model_q[$];
    logic                halt;
    logic [tag_w-1:0]    next_tag;
    int                  ops_sent;
    int                  retired;
    int                  dropped;
    int                  hold_left;
    logic                hold_started;
    logic                saw_full;
    logic                prev_valid;
    logic                prev_ready;
    retire_t             prev_data;

    rob_commit_top uut (
        .clk            (clk),
        .rst_n          (rst_n),
        .single_step    (single_step),
        .dispatch_valid (dispatch_valid),
        .dispatch_data  (dispatch_data),
        .dispatch_ready (dispatch_ready),
        .dispatch_tag   (dispatch_tag),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .wake           (wake),
        .retire_valid   (retire_valid),
        .retire_data    (retire_data),
        .retire_ready   (retire_ready)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic check_retire(input retire_t got, input retire_t exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t retire_data got %h expected %h", $time, got, exp));
        end
    endtask

    task automatic check_dispatch_tag(input logic [tag_w-1:0] got, input logic [tag_w-1:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("[FAIL] %0t dispatch_tag got %h expected %h", $time, got, exp));
        end
    endtask

    function automatic window_t head_window();
        window_t win;

        win = '0;
        for (int i = 0; i < commit_w; i++) begin
            if (i < model_q.size()) begin
                win[i] = model_q[i];
            end
        end
        return win;
    endfunction

    // ------------------------------
    // expected retire group
    // ------------------------------
    function automatic retire_t ref_retire(input window_t win, input logic step);
        retire_t   res;
        op_class_e cls;
        logic      solo;
        int        stores;
        int        csrs;

        res = '0;
        res.flags.branch_slot = no_branch;
        stores = 0;
        csrs = 0;
        for (int i = 0; i < commit_w; i++) begin
            cls = win[i].op_class;
            solo = (cls == excp) || (cls == ertn) || (cls == idle);
            if (!win[i].occupied || !win[i].done || (step && i > 0)) break;
            if (solo && i > 0) break;
            if ((cls == store && stores > 0) || (cls == csr_wr && csrs > 0)) break;
            res.mask[i] = 1'b1;
            res.tag[i] = win[i].tag;
            res.pc[i] = win[i].pc;
            stores += (cls == store) ? 1 : 0;
            csrs += (cls == csr_wr) ? 1 : 0;
            res.flags.find_store |= (cls == store);
            res.flags.find_csr_wr |= (cls == csr_wr);
            res.flags.find_excp = (cls == excp);
            res.flags.find_ertn = (cls == ertn);
            res.flags.find_idle = (cls == idle);
            if (cls == branch) begin
                res.flags.find_branch = 1'b1;
                res.flags.branch_slot = slot_w'(i);
            end
            // a branch or a solo op closes the group
            if (solo || cls == branch) break;
        end
        res.flags.mask = res.mask;
        return res;
    endfunction

    function automatic op_class_e pick_class(input int n);
        int unsigned r;

        r = $urandom % 20;
        if (n >= 60 && n < 140 && r >= 17) begin
            return (r == 17) ? excp : ((r == 18) ? ertn : idle);
        end
        if (r < 8) return plain;
        if (r < 11) return branch;
        if (r < 14) return store;
        if (r < 17) return csr_wr;
        return plain;
    endfunction

    // ------------------------------
    // compare and model update
    // ------------------------------
    always @(posedge clk) begin
        retire_t exp;
        logic    exp_valid;
        logic    exp_fire;
        logic    exp_flush;
        logic    exp_ready;
        int      n;

        if (!rst_n) begin
            model_q.delete();
            halt = 1'b0;
            next_tag = '0;
            prev_valid = 1'b0;
        end else begin
            exp = ref_retire(head_window(), single_step);
            exp_valid = (exp.mask != '0) && !halt;
            exp_fire = exp_valid && retire_ready;
            exp_flush = exp_fire && (exp.flags.find_excp || exp.flags.find_ertn);
            exp_ready = (model_q.size() < rob_depth) && !exp_flush;
            check_flag("retire_valid", retire_valid, exp_valid);
            if (exp_valid) check_retire(retire_data, exp);
            check_flag("dispatch_ready", dispatch_ready, exp_ready);
            check_dispatch_tag(dispatch_tag, next_tag);
            // held group must not move
            if (prev_valid && !prev_ready) begin
                check_flag("retire_valid held", retire_valid, 1'b1);
                check_retire(retire_data, prev_data);
            end
            prev_valid = exp_valid;
            prev_ready = retire_ready;
            prev_data = exp;
            // ops handed over by the DUT
            if (retire_valid && retire_ready) retired += $countones(retire_data.mask);

            if (complete_valid) begin
                foreach (model_q[i]) begin
                    if (model_q[i].tag == complete_tag) model_q[i].done = 1'b1;
                end
            end
            if (exp_fire) begin
                n = $countones(exp.mask);
                for (int i = 0; i < n; i++) void'(model_q.pop_front());
                if (exp_flush) begin
                    dropped += model_q.size();
                    model_q.delete();
                end
            end
            if (exp_fire && exp.flags.find_idle) halt = 1'b1;
            else if (wake) halt = 1'b0;
            if (model_q.size() == rob_depth && dispatch_valid) saw_full = 1'b1;
            if (dispatch_valid && exp_ready) begin
                model_q.push_back({1'b0, 1'b1, dispatch_data.op_class, next_tag,
                                   dispatch_data.pc});
                next_tag = next_tag + tag_w'(1);
                ops_sent++;
            end
        end
    end

    // ------------------------------
    // stimulus on the falling edge
    // ------------------------------
    task automatic drive_cycle();
        int   open_idx[$];
        logic hold;

        if (!hold_started && ops_sent >= 20) begin
            hold_started = 1'b1;
            hold_left = 40;
        end
        hold = (hold_left > 0);
        if (hold) hold_left--;
        // no completions while held so the group stays put
        retire_ready = !hold;
        single_step = (ops_sent >= 110) && (ops_sent < 140);
        wake = !hold && ($urandom % 6 == 0);
        dispatch_valid = (ops_sent < n_ops) && (hold || ($urandom % 4 != 0));
        dispatch_data.pc = $urandom & 32'hffff_fffc;
        dispatch_data.op_class = pick_class(ops_sent);
        complete_valid = 1'b0;
        if (!hold && ($urandom % 10 < 7)) begin
            foreach (model_q[i]) begin
                if (!model_q[i].done) open_idx.push_back(i);
            end
            if (open_idx.size() > 0) begin
                complete_valid = 1'b1;
                complete_tag = model_q[open_idx[$urandom % open_idx.size()]].tag;
            end
        end
    endtask

    initial begin
        #(n_ops * 40 * clk_period);
        stop_run("watchdog timeout, commit did not drain in time");
    end

    initial begin
        void'($urandom(seed));
        clk = 1'b0;
        rst_n = 1'b0;
        single_step = 1'b0;
        dispatch_valid = 1'b0;
        dispatch_data = '0;
        complete_valid = 1'b0;
        complete_tag = '0;
        wake = 1'b0;
        retire_ready = 1'b1;
        ops_sent = 0;
        retired = 0;
        dropped = 0;
        hold_left = 0;
        hold_started = 1'b0;
        saw_full = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        while (!(ops_sent == n_ops && model_q.size() == 0 && !halt)) begin
            drive_cycle();
            @(negedge clk);
        end
        if (saw_full && (retired + dropped == n_ops)) begin
            $display("Done: no errors");
            $finish;
        end else begin
            stop_run($sformatf(
                "end of run mismatch: full seen %0b, retired %0d, flushed %0d, sent %0d",
                saw_full, retired, dropped, n_ops));
        end
    end

endmodule

`default_nettype wire

// File: vlog.f
rob_pkg.sv
rob_queue.sv
commit_mask.sv
retire_unit.sv
rob_commit_top.sv
rob_commit_chk.sv
tb_rob_commit.sv
